//--- flist.f
+incdir+design
+incdir+verif
design/dmem_pkg.sv
design/delay_counter.sv
design/dmem_bank.sv
design/bank_steer.sv
design/dmem_top.sv
verif/dmem_tb.sv

//--- run.sh
#!/bin/sh
# builds the testbench with Verilator, runs it and looks for the pass line in the log

verilator --binary --timing --assert -f flist.f --top-module dmem_tb -o dmem_sim \
	> build.log 2>&1 \
	|| { cat build.log; echo "build failed"; exit 1; }

./obj_dir/dmem_sim > sim.log 2>&1
cat sim.log

grep -q "^Test OK$" sim.log \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }

//--- verif/dmem_ref_model.svh
// reference model of the banked data memory for the testbench
// included inside the testbench module body, after dmem_pkg is imported
// keeps the expected block per address and a written flag per block

`ifndef DMEM_REF_MODEL_SVH
`define DMEM_REF_MODEL_SVH

localparam int NUM_BLOCKS = `DMEM_SIZE_BLOCKS;

// counter saturates after 2**n - 1 edges, the registered answer comes one edge later
localparam int ANSWER_EDGES = 1 << `DMEM_DELAY_CNTR_SIZE;

// expected contents and which blocks hold known data
dblock_u model_mem [0:NUM_BLOCKS-1];
bit model_written [0:NUM_BLOCKS-1];

function automatic void model_clear();
	for (int i = 0; i < NUM_BLOCKS; i++)
	begin
		model_mem[i] = '0;
		model_written[i] = 1'b0;
	end
endfunction

// a write that got done becomes the latest value of the block
function automatic void model_store(input int addr, input dblock_u data);
	model_mem[addr] = data;
	model_written[addr] = 1'b1;
endfunction

function automatic dblock_u model_fetch(input int addr);
	return model_mem[addr];
endfunction

// fresh random block, filled word by word
function automatic dblock_u random_block();
	dblock_u blk;
	for (int w = 0; w < `DBLOCK_SIZE_WORDS; w++)
	begin
		blk.words[w] = $urandom;
	end
	return blk;
endfunction

// bit 0 of the block address is the bank
function automatic int random_addr_in_bank(input int bank);
	return int'($urandom % (NUM_BLOCKS / 2)) * 2 + bank;
endfunction

`endif

//--- verif/dmem_tb.sv
// testbench for the banked block data memory
// writes every block, then runs seeded random reads, mixed traffic and
// back-to-back reads inside one bank and across banks
// every answer is compared with the reference model, errors are counted

`timescale 1ns/100ps

`include "dmem_defines.svh"

module dmem_tb
	import dmem_pkg::*;
;

	`include "dmem_ref_model.svh"

	localparam int SEED = 32'hf5aec594;
	localparam int NUM_READS = 300;
	localparam int MIXED_OPS = 200;
	localparam int BURSTS = 20;
	localparam int MAX_BURST = 5;
	localparam int CROSSES = 20;
	localparam int HOPS = 3;
	// a request that is not answered within this many edges is given up
	localparam int ANSWER_LIMIT = 16;

	// worst case number of requests over all phases
	localparam int TOTAL_REQS = NUM_BLOCKS + NUM_READS + 3 * MIXED_OPS
		+ BURSTS * MAX_BURST + CROSSES * (HOPS + 1);

	logic clock;
	logic reset;
	logic ren;
	logic wen;
	block_addr_t block_address;
	dblock_u din;
	logic ready;
	logic done;
	dblock_u dout;

	int errors;
	int checks;

	dmem_top dmem_top_i
	(
		.clock         (clock),
		.reset         (reset),
		.ren           (ren),
		.wen           (wen),
		.block_address (block_address),
		.din           (din),
		.ready         (ready),
		.done          (done),
		.dout          (dout)
	);

	// 8 ns clock
	initial clock = 1'b0;
	always #4 clock = ~clock;

	// ends a run that stops making progress
	initial
	begin
		repeat (TOTAL_REQS * 20 + 200) @(posedge clock);
		$display("watchdog expired, the memory stopped answering requests");
		$display("Test FAILED");
		$finish;
	end

	// idle gap of 1 to 3 cycles between requests
	task automatic idle_gap();
		int n;
		n = 1 + int'($urandom % 3);
		repeat (n) @(negedge clock);
	endtask

	// counts rising edges until the answer, sampled on falling edges
	task automatic wait_answer(input bit is_read, output int edges);
		bit got;
		got = 1'b0;
		edges = 0;
		while (!got && edges < ANSWER_LIMIT)
		begin
			@(posedge clock);
			edges++;
			@(negedge clock);
			checks++;
			// the other strobe's answer never shows up
			if (is_read)
			begin
				got = ready;
				assert (!done) else
				begin
					errors++;
					$display("Fail %0t: done seen during a read", $time);
				end
			end
			else
			begin
				got = done;
				assert (!ready) else
				begin
					errors++;
					$display("Fail %0t: ready seen during a write", $time);
				end
			end
		end
		assert (got) else
		begin
			errors++;
			$display("request at %0t got no answer within %0d edges", $time, ANSWER_LIMIT);
		end
	endtask

	task automatic check_latency(input int edges);
		checks++;
		assert (edges == ANSWER_EDGES) else
		begin
			errors++;
			$display("Fail %0t: answer after %0d edges, expected %0d",
				$time, edges, ANSWER_EDGES);
		end
	endtask

	// flat compare, then each word against its slice of the flat view
	task automatic check_read_data(input int addr);
		dblock_u exp;
		exp = model_fetch(addr);
		checks++;
		// a block whose writes were never answered has no known contents
		assert (model_written[addr]) else
		begin
			errors++;
			$display("block %0d was read but no write to it was ever answered", addr);
		end
		checks++;
		assert (dout.bits == exp.bits) else
		begin
			errors++;
			$display("Fail %0t: block %0d read %h expected %h",
				$time, addr, dout.bits, exp.bits);
		end
		for (int w = 0; w < `DBLOCK_SIZE_WORDS; w++)
		begin
			checks++;
			assert (dout.words[w] == exp.bits[w*`DWORD_SIZE_BITS +: `DWORD_SIZE_BITS]) else
			begin
				errors++;
				$display("Fail %0t: block %0d word %0d is %h", $time, addr, w, dout.words[w]);
			end
		end
	endtask

	task automatic do_write(input int addr, input dblock_u data);
		int edges;
		block_address = addr[`DMEM_BLOCK_ADDR_SIZE-1:0];
		din = data;
		wen = 1'b1;
		wait_answer(1'b0, edges);
		check_latency(edges);
		// only a write that got done changes the expected contents
		if (done)
		begin
			model_store(addr, data);
		end
		wen = 1'b0;
		idle_gap();
	endtask

	task automatic do_read(input int addr);
		int edges;
		block_address = addr[`DMEM_BLOCK_ADDR_SIZE-1:0];
		ren = 1'b1;
		wait_answer(1'b1, edges);
		check_latency(edges);
		check_read_data(addr);
		ren = 1'b0;
		idle_gap();
	endtask

	// ren held, address moves inside one bank, answers come at once
	task automatic read_burst_same_bank(input int count);
		int bank;
		int addr;
		int edges;
		bank = int'($urandom % 2);
		addr = random_addr_in_bank(bank);
		block_address = addr[`DMEM_BLOCK_ADDR_SIZE-1:0];
		ren = 1'b1;
		wait_answer(1'b1, edges);
		check_latency(edges);
		check_read_data(addr);
		for (int k = 1; k < count; k++)
		begin
			addr = random_addr_in_bank(bank);
			block_address = addr[`DMEM_BLOCK_ADDR_SIZE-1:0];
			@(posedge clock);
			@(negedge clock);
			checks++;
			assert (ready) else
			begin
				errors++;
				$display("Fail %0t: ready dropped inside a bank burst", $time);
			end
			check_read_data(addr);
		end
		ren = 1'b0;
		idle_gap();
	endtask

	// ren held, address hops between banks, each hop waits the full delay
	task automatic read_cross_banks(input int hops);
		int bank;
		int addr;
		int edges;
		bank = int'($urandom % 2);
		ren = 1'b1;
		for (int k = 0; k <= hops; k++)
		begin
			addr = random_addr_in_bank(bank);
			block_address = addr[`DMEM_BLOCK_ADDR_SIZE-1:0];
			wait_answer(1'b1, edges);
			check_latency(edges);
			check_read_data(addr);
			bank = 1 - bank;
		end
		ren = 1'b0;
		idle_gap();
	endtask

	initial
	begin
		int op;
		int addr;
		reset = 1'b0;
		ren = 1'b0;
		wen = 1'b0;
		block_address = '0;
		din = '0;
		errors = 0;
		checks = 0;
		void'($urandom(SEED));
		model_clear();

		// reset for 4 cycles
		repeat (4) @(negedge clock);
		reset = 1'b1;
		@(negedge clock);

		// quiet outputs before any request
		checks++;
		assert (!ready && !done && dout.bits == '0) else
		begin
			errors++;
			$display("Fail %0t: outputs not idle after reset", $time);
		end

		// fill every block
		for (int a = 0; a < NUM_BLOCKS; a++)
		begin
			do_write(a, random_block());
		end

		// random reads of known blocks
		for (int i = 0; i < NUM_READS; i++)
		begin
			do_read(int'($urandom % NUM_BLOCKS));
		end

		// mixed traffic where op 2 rewrites one block twice and reads it back
		for (int i = 0; i < MIXED_OPS; i++)
		begin
			op = int'($urandom % 3);
			addr = int'($urandom % NUM_BLOCKS);
			if (op == 0)
			begin
				do_write(addr, random_block());
			end
			else if (op == 1)
			begin
				do_read(addr);
			end
			else
			begin
				do_write(addr, random_block());
				do_write(addr, random_block());
				do_read(addr);
			end
		end

		for (int i = 0; i < BURSTS; i++)
		begin
			read_burst_same_bank(2 + int'($urandom % (MAX_BURST - 1)));
		end

		for (int i = 0; i < CROSSES; i++)
		begin
			read_cross_banks(HOPS);
		end

		$display("checks %0d errors %0d", checks, errors);
		if (errors == 0)
		begin
			$display("Test OK");
		end
		else
		begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule

//--- design/dmem_top.sv
// top level of the banked block data memory
// hold ren or wen with a steady address and data until ready or done
// a read answers with ready and the block on dout, a write with done
// keeping ren high on the same bank gives later reads with no delay
// both strobes high at once is illegal and is never answered

`timescale 1ns/100ps

module dmem_top
	import dmem_pkg::*;
(
	input logic clock,
	input logic reset,
	input logic ren,
	input logic wen,
	input block_addr_t block_address,
	input dblock_u din,
	output logic ready,
	output logic done,
	output dblock_u dout
);

	// per bank request and answer
	dmem_req_t req0;
	dmem_req_t req1;
	dmem_rsp_t rsp0;
	dmem_rsp_t rsp1;

	// splits the address and merges the answers
	bank_steer steer
	(
		.ren           (ren),
		.wen           (wen),
		.block_address (block_address),
		.din           (din),
		.req0          (req0),
		.req1          (req1),
		.rsp0          (rsp0),
		.rsp1          (rsp1),
		.ready         (ready),
		.done          (done),
		.dout          (dout)
	);

	// even blocks
	dmem_bank bank0
	(
		.clock (clock),
		.reset (reset),
		.req   (req0),
		.rsp   (rsp0)
	);

	// odd blocks
	dmem_bank bank1
	(
		.clock (clock),
		.reset (reset),
		.req   (req1),
		.rsp   (rsp1)
	);

endmodule

//--- design/bank_steer.sv
// steering between the caller and the two interleaved banks
// block address bit 0 picks the bank, the upper bits address inside it
// only the chosen bank sees a strobe, the other one stays idle
// the chosen bank's answer is passed straight back to the caller

`timescale 1ns/100ps

`include "dmem_defines.svh"

module bank_steer
	import dmem_pkg::*;
(
	input logic ren,
	input logic wen,
	input block_addr_t block_address,
	input dblock_u din,
	output dmem_req_t req0,
	output dmem_req_t req1,
	input dmem_rsp_t rsp0,
	input dmem_rsp_t rsp1,
	output logic ready,
	output logic done,
	output dblock_u dout
);

	logic bank_sel;
	bank_addr_t bank_addr;

	// even blocks live in bank 0, odd blocks in bank 1
	assign bank_sel = block_address[0];
	assign bank_addr = block_address[`DMEM_BLOCK_ADDR_SIZE-1:1];

	// request side
	// address and data go to both banks, only the strobes are steered
	always_comb
	begin
		req0.addr = bank_addr;
		req0.din = din;
		req1.addr = bank_addr;
		req1.din = din;

		// bank 0 strobes
		req0.ren = ren && !bank_sel;
		req0.wen = wen && !bank_sel;

		// bank 1 strobes
		req1.ren = ren && bank_sel;
		req1.wen = wen && bank_sel;
	end

	// response side
	// no register here, the banks already register ready and done
	// moving the address to the other bank switches the answer at once,
	// so ready falls until the new bank finishes its own delay
	always_comb
	begin
		if (bank_sel)
		begin
			ready = rsp1.ready;
			done = rsp1.done;
			dout = rsp1.dout;
		end
		else
		begin
			ready = rsp0.ready;
			done = rsp0.done;
			dout = rsp0.dout;
		end
	end

endmodule

//--- design/dmem_bank.sv
// one bank of the block data memory
// answers a held read or write after the fixed access delay
// a read held on this bank keeps answering at once for new addresses
// write data is taken on the first edge of the request and stored on the grant

`timescale 1ns/100ps

`include "dmem_defines.svh"

module dmem_bank
	import dmem_pkg::*;
(
	input logic clock,
	input logic reset,
	input dmem_req_t req,
	output dmem_rsp_t rsp
);

	// block storage, one row of words per block
	dword_t mem [0:`DMEM_BANK_BLOCKS-1][0:`DBLOCK_SIZE_WORDS-1];

	// write data capture
	dblock_u wdata_q;
	logic cap_valid;

	logic rd_req;
	logic wr_req;
	logic cnt_clear;
	logic expired;
	logic rd_grant;
	logic wr_grant;

	logic ready_q;
	logic done_q;
	dblock_u rd_block;

	// exactly one strobe makes a legal request
	assign rd_req = req.ren && !req.wen;
	assign wr_req = req.wen && !req.ren;

	// idle or both strobes high, the delay stays at zero
	assign cnt_clear = !(rd_req || wr_req);

	delay_counter delay_cntr
	(
		.clock   (clock),
		.clear   (cnt_clear),
		.reset   (reset),
		.expired (expired)
	);

	// counter state is one edge old, so the strobes gate the grant too
	assign rd_grant = expired && rd_req;
	assign wr_grant = expired && wr_req;

	// registered answer, one edge after the grant
	always_ff @(posedge clock or negedge reset)
	begin
		if (!reset)
		begin
			ready_q <= 1'b0;
			done_q <= 1'b0;
		end
		else
		begin
			ready_q <= rd_grant;
			done_q <= wr_grant;
		end
	end

	// capture flag, set on the first edge of a write
	// cleared as soon as the write request goes away
	always_ff @(posedge clock or negedge reset)
	begin
		if (!reset)
		begin
			cap_valid <= 1'b0;
		end
		else
		begin
			cap_valid <= wr_req;
		end
	end

	// din is taken once per write request
	always_ff @(posedge clock)
	begin
		if (wr_req && !cap_valid)
		begin
			wdata_q <= req.din;
		end
	end

	// store on the grant edge, the same edge that raises done
	// a held write stores the same captured block again
	always_ff @(posedge clock)
	begin
		if (wr_grant)
		begin
			for (int i = 0; i < `DBLOCK_SIZE_WORDS; i++)
			begin
				mem[req.addr][i] <= wdata_q.words[i];
			end
		end
	end

	// read data follows the address while ready is up, zero otherwise
	always_comb
	begin
		rd_block = '0;
		if (ready_q)
		begin
			for (int i = 0; i < `DBLOCK_SIZE_WORDS; i++)
			begin
				rd_block.words[i] = mem[req.addr][i];
			end
		end
	end

	assign rsp = '{ready: ready_q, done: done_q, dout: rd_block};

endmodule

//--- design/delay_counter.sv
// access delay counter for one memory bank
// counts up while a legal request is held and sticks at all-ones
// expired tells the bank that the access delay has run out

`timescale 1ns/100ps

`include "dmem_defines.svh"

module delay_counter
(
	input logic clock,
	input logic clear,
	input logic reset,
	output logic expired
);

	logic [`DMEM_DELAY_CNTR_SIZE-1:0] count;

	// saturated counter means the delay is over
	assign expired = &count;

	always_ff @(posedge clock or negedge reset)
	begin
		if (!reset)
		begin
			count <= '0;
		end
		else if (clear)
		begin
			// idle or illegal request keeps the delay from starting
			count <= '0;
		end
		else if (!expired)
		begin
			count <= count + 1'b1;
		end
	end

endmodule

//--- design/dmem_pkg.sv
// shared types of the banked data memory
// modules pull these in with a wildcard import in their header
// block is a packed union so it can be used flat or per word

`include "dmem_defines.svh"

package dmem_pkg;

	// one memory word
	typedef logic [`DWORD_SIZE_BITS-1:0] dword_t;

	// a whole block, seen either as a flat vector or as words
	// word 0 lands in the low bits of the flat view
	typedef union packed
	{
		logic [`DBLOCK_SIZE_BITS-1:0] bits;
		dword_t [`DBLOCK_SIZE_WORDS-1:0] words;
	} dblock_u;

	// block address as the caller gives it
	typedef logic [`DMEM_BLOCK_ADDR_SIZE-1:0] block_addr_t;

	// address inside one bank, bit 0 of the block address is dropped
	typedef logic [`DMEM_BLOCK_ADDR_SIZE-2:0] bank_addr_t;

	// request seen by one bank
	// strobes are levels held by the caller until the answer comes
	typedef struct packed
	{
		logic ren;
		logic wen;
		bank_addr_t addr;
		dblock_u din;
	} dmem_req_t;

	// answer from one bank
	// ready flags read data, done flags a stored write
	typedef struct packed
	{
		logic ready;
		logic done;
		dblock_u dout;
	} dmem_rsp_t;

endpackage

//--- design/dmem_defines.svh
// size and timing constants for the banked data memory
// included by the package and by every module that needs a width
// the bank split and the access delay are derived from these values

`ifndef DMEM_DEFINES_SVH
`define DMEM_DEFINES_SVH

// one data word
`define DWORD_SIZE_BITS 32

// words per cache block
`define DBLOCK_SIZE_WORDS 4

// whole block in bits, 128 with the values above
`define DBLOCK_SIZE_BITS (`DWORD_SIZE_BITS * `DBLOCK_SIZE_WORDS)

// total number of blocks held by the memory
`define DMEM_SIZE_BLOCKS 64

// two interleaved banks share the blocks evenly
`define DMEM_BANK_BLOCKS (`DMEM_SIZE_BLOCKS / 2)

// block address width, log2 of the block count
`define DMEM_BLOCK_ADDR_SIZE 6

// delay counter width
// the counter saturates at all-ones, so 2 bits give a 3 cycle delay
// before the registered answer
`define DMEM_DELAY_CNTR_SIZE 2

`endif
